// ==== source/ccl_pkg.sv ====
// shared image sizes, label widths and bus structs; imported by every stage and the testbench
package ccl_pkg;

    localparam int IMG_W      = 32;
    localparam int IMG_H      = 16;
    localparam int NUM_LABELS = 256;    // label 0 is background
    localparam int FIFO_DEPTH = 512;    // one entry per pixel, never fills

    typedef logic [4:0]  x_t;
    typedef logic [3:0]  y_t;
    typedef logic [7:0]  label_t;
    typedef logic [9:0]  area_t;        // up to 512
    typedef logic [11:0] perim_t;       // up to 2048

    // two provisional labels that belong to one component
    typedef struct packed {
        label_t a;
        label_t b;
    } union_req_t;

    // per pixel table update
    typedef struct packed {
        label_t     label;
        logic [2:0] incr;               // perimeter increment 0, 2 or 4
    } pix_update_t;

    // table entry and output record
    typedef struct packed {
        area_t  area;
        perim_t perimeter;
    } obj_info_t;

endpackage

// ==== source/pixel_decode.sv ====
// first pass: assigns provisional labels to the pixel stream, feeds the stat tables and union queue
`timescale 1ns/1ps

module pixel_decode import ccl_pkg::*; (
    input  logic        clk,
    input  logic        rst_fifo,
    input  logic        frame_start_i,
    input  logic        pix_valid_i,
    input  logic        pix_i,
    output logic        upd_en_o,
    output pix_update_t upd_o,
    output logic        push_o,
    output union_req_t  push_req_o,
    output logic        frame_end_o,
    output label_t      label_count_o,
    output logic        overflow_o
);

    x_t     x;
    y_t     y;
    label_t line_buf [IMG_W];   // labels of the row above
    label_t left_q;
    label_t label_count;
    logic   overflow;

    label_t left_label;
    label_t above_label;
    label_t cur_label;
    logic   left_fg;
    logic   above_fg;
    logic   need_fresh;

    // border counts as background
    assign left_label  = (x == '0) ? '0 : left_q;
    assign above_label = (y == '0) ? '0 : line_buf[x];
    assign left_fg     = (left_label != '0);
    assign above_fg    = (above_label != '0);
    assign need_fresh  = !left_fg && !above_fg;

    always_comb begin
        if (!pix_i) begin
            cur_label = '0;
        end else if (need_fresh) begin
            cur_label = (label_count == label_t'(NUM_LABELS - 1)) ? '0 : label_count + 1'b1;
        end else if (left_fg && above_fg) begin
            cur_label = (left_label < above_label) ? left_label : above_label;
        end else begin
            cur_label = left_label | above_label;   // only one is nonzero
        end
    end

    assign upd_en_o    = pix_valid_i && (cur_label != '0);
    assign upd_o.label = cur_label;
    assign upd_o.incr  = 3'd4 - (left_fg ? 3'd2 : 3'd0) - (above_fg ? 3'd2 : 3'd0);

    // clash between two different neighbour labels
    assign push_o       = pix_valid_i && pix_i && left_fg && above_fg && (left_label != above_label);
    assign push_req_o.a = left_label;
    assign push_req_o.b = above_label;

    always_ff @(posedge clk) begin
        if (rst_fifo || frame_start_i) begin
            x           <= '0;
            y           <= '0;
            label_count <= '0;
            overflow    <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            frame_end_o <= pix_valid_i && (x == x_t'(IMG_W - 1)) && (y == y_t'(IMG_H - 1));
            if (pix_valid_i) begin
                x <= x + 1'b1;  // wraps at the row end
                if (x == x_t'(IMG_W - 1))
                    y <= y + 1'b1;
                if (pix_i && need_fresh) begin
                    if (label_count == label_t'(NUM_LABELS - 1))
                        overflow <= 1'b1;   // sticky
                    else
                        label_count <= label_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            line_buf[x] <= cur_label;
            left_q      <= cur_label;
        end
    end

    assign label_count_o = label_count;
    assign overflow_o    = overflow;

endmodule

// ==== source/union_fifo.sv ====
// circular queue of union requests between the pixel decoder and the union engine
`timescale 1ns/1ps

module union_fifo import ccl_pkg::*; (
    input  logic       clk,
    input  logic       rst_fifo,
    input  logic       frame_start_i,
    input  logic       push_i,
    input  union_req_t push_req_i,
    input  logic       pop_i,
    output union_req_t pop_req_o,
    output logic       empty_o
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0] addr_t;
    typedef logic [$clog2(FIFO_DEPTH):0]   ptr_t;   // extra wrap bit

    union_req_t mem [FIFO_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;

    always_ff @(posedge clk) begin
        if (rst_fifo || frame_start_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i)
            mem[addr_t'(wr_ptr)] <= push_req_i;
        if (pop_i)
            pop_req_o <= mem[addr_t'(rd_ptr)];  // data valid the cycle after pop
    end

    assign empty_o = (wr_ptr == rd_ptr);

endmodule

// ==== source/union_engine.sv ====
// union-find engine: drains the union queue into the parent table and answers root lookups
`timescale 1ns/1ps

module union_engine import ccl_pkg::*; (
    input  logic       clk,
    input  logic       rst_fifo,
    input  logic       frame_start_i,
    input  logic       fifo_empty_i,
    input  union_req_t pop_req_i,
    input  logic       find_req_i,
    input  label_t     find_label_i,
    output logic       pop_o,
    output logic       find_done_o,
    output label_t     find_root_o,
    output logic       engine_idle_o
);

    typedef enum logic [2:0] {
        idle,
        pop,
        walk_a,
        walk_b,
        reply
    } state_t;

    state_t state;
    label_t parent [NUM_LABELS];
    label_t a_q;
    label_t b_q;
    logic   is_find;    // walk_a ends in reply instead of walk_b

    always_ff @(posedge clk) begin
        if (rst_fifo || frame_start_i) begin
            state   <= idle;
            is_find <= 1'b0;
            for (int i = 0; i < NUM_LABELS; i++)
                parent[i] <= label_t'(i);   // every label its own root
        end else begin
            case (state)
                idle: begin
                    if (!fifo_empty_i) begin
                        is_find <= 1'b0;
                        state   <= pop;
                    end else if (find_req_i) begin
                        a_q     <= find_label_i;
                        is_find <= 1'b1;
                        state   <= walk_a;
                    end
                end
                pop: begin
                    a_q   <= pop_req_i.a;
                    b_q   <= pop_req_i.b;
                    state <= walk_a;
                end
                walk_a: begin
                    if (parent[a_q] == a_q)
                        state <= is_find ? reply : walk_b;
                    else
                        a_q <= parent[a_q];     // one hop per cycle
                end
                walk_b: begin
                    if (parent[b_q] == b_q) begin
                        // larger root goes under the smaller one
                        if (a_q < b_q)
                            parent[b_q] <= a_q;
                        else if (b_q < a_q)
                            parent[a_q] <= b_q;
                        state <= idle;
                    end else begin
                        b_q <= parent[b_q];
                    end
                end
                reply: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign pop_o         = (state == idle) && !fifo_empty_i;
    assign find_done_o   = (state == reply);
    assign find_root_o   = a_q;
    assign engine_idle_o = (state == idle) && fifo_empty_i;

endmodule

// ==== source/label_stats.sv ====
// per label area and perimeter tables, fed by pixel updates and folded together by merges
`timescale 1ns/1ps

module label_stats import ccl_pkg::*; (
    input  logic        clk,
    input  logic        rst_fifo,
    input  logic        frame_start_i,
    input  logic        upd_en_i,
    input  pix_update_t upd_i,
    input  logic        merge_i,
    input  label_t      merge_src_i,
    input  label_t      merge_dst_i,
    input  label_t      rd_label_i,
    output obj_info_t   rd_stat_o
);

    area_t  area_tbl  [NUM_LABELS];
    perim_t perim_tbl [NUM_LABELS];

    always_ff @(posedge clk) begin
        if (rst_fifo || frame_start_i) begin
            for (int i = 0; i < NUM_LABELS; i++) begin
                area_tbl[i]  <= '0;
                perim_tbl[i] <= '0;
            end
        end else if (upd_en_i) begin
            area_tbl[upd_i.label]  <= area_tbl[upd_i.label] + 1'b1;
            perim_tbl[upd_i.label] <= perim_tbl[upd_i.label] + perim_t'(upd_i.incr);
        end else if (merge_i) begin
            // fold a child label into its root
            area_tbl[merge_dst_i]  <= area_tbl[merge_dst_i] + area_tbl[merge_src_i];
            perim_tbl[merge_dst_i] <= perim_tbl[merge_dst_i] + perim_tbl[merge_src_i];
        end
    end

    // pixel updates and merges never overlap, merges only run after frame end

    assign rd_stat_o.area      = area_tbl[rd_label_i];
    assign rd_stat_o.perimeter = perim_tbl[rd_label_i];

endmodule

// ==== source/result_emit.sv ====
// second pass: resolves every label to its root, merges stats, then streams one record per root
`timescale 1ns/1ps

module result_emit import ccl_pkg::*; (
    input  logic      clk,
    input  logic      rst_fifo,
    input  logic      frame_end_i,
    input  label_t    label_count_i,
    input  logic      overflow_i,
    input  logic      engine_idle_i,
    input  logic      find_done_i,
    input  label_t    find_root_i,
    input  obj_info_t rd_stat_i,
    output logic      find_req_o,
    output label_t    find_label_o,
    output logic      merge_o,
    output label_t    merge_src_o,
    output label_t    merge_dst_o,
    output label_t    rd_label_o,
    output logic      obj_valid_o,
    output obj_info_t obj_o,
    output logic      frame_done_o,
    output logic      label_overflow_o
);

    typedef enum logic [2:0] {
        wait_end,
        wait_idle,
        find,
        merge,
        emit,
        done
    } state_t;

    state_t                 state;
    label_t                 cur;
    label_t                 count_q;
    label_t                 root_q;
    logic [NUM_LABELS-1:0]  root_map;   // labels that are their own root
    logic                   last;

    assign last = (cur == count_q);

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            state            <= wait_end;
            obj_valid_o      <= 1'b0;
            frame_done_o     <= 1'b0;
            label_overflow_o <= 1'b0;
        end else begin
            obj_valid_o  <= (state == emit) && root_map[cur];
            frame_done_o <= (state == done);
            case (state)
                wait_end: begin
                    if (frame_end_i) begin
                        cur              <= 8'd1;
                        count_q          <= label_count_i;
                        root_map         <= '0;
                        label_overflow_o <= overflow_i;
                        state            <= wait_idle;
                    end
                end
                wait_idle: begin
                    // union queue drained before any lookup
                    if (engine_idle_i)
                        state <= (count_q == '0) ? done : find;
                end
                find: begin
                    if (find_done_i) begin
                        root_q <= find_root_i;
                        if (find_root_i == cur) begin
                            root_map[cur] <= 1'b1;
                            cur           <= last ? 8'd1 : cur + 1'b1;
                            state         <= last ? emit : wait_idle;
                        end else begin
                            state <= merge;
                        end
                    end
                end
                merge: begin
                    cur   <= last ? 8'd1 : cur + 1'b1;
                    state <= last ? emit : wait_idle;
                end
                emit: begin
                    obj_o <= rd_stat_i;
                    if (last)
                        state <= done;
                    else
                        cur <= cur + 1'b1;
                end
                done: state <= wait_end;
                default: state <= wait_end;
            endcase
        end
    end

    assign find_req_o   = (state == wait_idle) && engine_idle_i && (count_q != '0);
    assign find_label_o = cur;
    assign merge_o      = (state == merge);   // root is always below cur, so already final
    assign merge_src_o  = cur;
    assign merge_dst_o  = root_q;
    assign rd_label_o   = cur;

endmodule

// ==== source/ccl_top.sv ====
// top level of the two pass labeller; connects decode, union queue, engine, tables and emitter
`timescale 1ns/1ps

module ccl_top import ccl_pkg::*; (
    input  logic      clk,
    input  logic      rst_fifo,
    input  logic      frame_start_i,
    input  logic      pix_valid_i,
    input  logic      pix_i,
    output logic      obj_valid_o,
    output obj_info_t obj_o,
    output logic      frame_done_o,
    output logic      label_overflow_o
);

    logic        upd_en;
    pix_update_t upd;
    logic        push;
    union_req_t  push_req;
    logic        pop;
    union_req_t  pop_req;
    logic        fifo_empty;
    logic        frame_end;
    label_t      label_count;
    logic        overflow;
    logic        find_req;
    label_t      find_label;
    logic        find_done;
    label_t      find_root;
    logic        engine_idle;
    logic        merge;
    label_t      merge_src;
    label_t      merge_dst;
    label_t      rd_label;
    obj_info_t   rd_stat;

    pixel_decode u_decode (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_start_i (frame_start_i),
        .pix_valid_i   (pix_valid_i),
        .pix_i         (pix_i),
        .upd_en_o      (upd_en),
        .upd_o         (upd),
        .push_o        (push),
        .push_req_o    (push_req),
        .frame_end_o   (frame_end),
        .label_count_o (label_count),
        .overflow_o    (overflow)
    );

    union_fifo u_fifo (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_start_i (frame_start_i),
        .push_i        (push),
        .push_req_i    (push_req),
        .pop_i         (pop),
        .pop_req_o     (pop_req),
        .empty_o       (fifo_empty)
    );

    union_engine u_engine (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_start_i (frame_start_i),
        .fifo_empty_i  (fifo_empty),
        .pop_req_i     (pop_req),
        .find_req_i    (find_req),
        .find_label_i  (find_label),
        .pop_o         (pop),
        .find_done_o   (find_done),
        .find_root_o   (find_root),
        .engine_idle_o (engine_idle)
    );

    label_stats u_stats (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_start_i (frame_start_i),
        .upd_en_i      (upd_en),
        .upd_i         (upd),
        .merge_i       (merge),
        .merge_src_i   (merge_src),
        .merge_dst_i   (merge_dst),
        .rd_label_i    (rd_label),
        .rd_stat_o     (rd_stat)
    );

    result_emit u_emit (
        .clk              (clk),
        .rst_fifo         (rst_fifo),
        .frame_end_i      (frame_end),
        .label_count_i    (label_count),
        .overflow_i       (overflow),
        .engine_idle_i    (engine_idle),
        .find_done_i      (find_done),
        .find_root_i      (find_root),
        .rd_stat_i        (rd_stat),
        .find_req_o       (find_req),
        .find_label_o     (find_label),
        .merge_o          (merge),
        .merge_src_o      (merge_src),
        .merge_dst_o      (merge_dst),
        .rd_label_o       (rd_label),
        .obj_valid_o      (obj_valid_o),
        .obj_o            (obj_o),
        .frame_done_o     (frame_done_o),
        .label_overflow_o (label_overflow_o)
    );

endmodule

// ==== tests/ccl_model.svh ====
// reference labeller for the testbench; flood fills a frame and predicts objects and overflow
`ifndef CCL_MODEL_SVH
`define CCL_MODEL_SVH

obj_info_t exp_obj [IMG_W*IMG_H];   // expected records in first pixel order
int        exp_count;
logic      exp_ovf;

function automatic void ccl_model(input logic [IMG_W*IMG_H-1:0] img);
    int comp  [IMG_W*IMG_H];        // component index per pixel, -1 when unvisited
    int stack [IMG_W*IMG_H];
    int sp;
    int p;
    int q;
    int px;
    int py;
    int nx;
    int ny;
    int fresh;
    exp_count = 0;
    fresh     = 0;
    for (int i = 0; i < IMG_W*IMG_H; i++)
        comp[i] = -1;
    for (int i = 0; i < IMG_W*IMG_H; i++) begin
        if (img[i] && comp[i] < 0) begin
            exp_obj[exp_count] = '0;
            comp[i]            = exp_count;
            stack[0]           = i;
            sp                 = 1;
            while (sp > 0) begin
                sp = sp - 1;
                p  = stack[sp];
                px = p % IMG_W;
                py = p / IMG_W;
                exp_obj[exp_count].area += 1'b1;
                for (int d = 0; d < 4; d++) begin
                    nx = px + ((d == 0) ? -1 : (d == 1) ? 1 : 0);
                    ny = py + ((d == 2) ? -1 : (d == 3) ? 1 : 0);
                    if (nx < 0 || nx >= IMG_W || ny < 0 || ny >= IMG_H) begin
                        exp_obj[exp_count].perimeter += 1'b1;   // border edge
                    end else begin
                        q = ny * IMG_W + nx;
                        if (!img[q]) begin
                            exp_obj[exp_count].perimeter += 1'b1;
                        end else if (comp[q] < 0) begin
                            comp[q]   = exp_count;  // marked on push, so pushed once
                            stack[sp] = q;
                            sp        = sp + 1;
                        end
                    end
                end
            end
            exp_count = exp_count + 1;
        end
    end
    // a fresh label is needed wherever no left or above neighbour is foreground
    for (int i = 0; i < IMG_W*IMG_H; i++) begin
        if (img[i] && (i % IMG_W == 0 || !img[i-1]) && (i < IMG_W || !img[i-IMG_W]))
            fresh = fresh + 1;
    end
    exp_ovf = (fresh > NUM_LABELS - 1);
endfunction

`endif

// ==== tests/ccl_tb.sv ====
// testbench for ccl_top; drives directed and random frames and checks every object record
`timescale 1ns/1ps

module ccl_tb import ccl_pkg::*; ();

    localparam int DONE_LIMIT = 20000;  // cycles allowed from last pixel to frame_done_o

    logic      clk = 1'b0;
    logic      rst_fifo;
    logic      frame_start_i;
    logic      pix_valid_i;
    logic      pix_i;
    logic      obj_valid_o;
    obj_info_t obj_o;
    logic      frame_done_o;
    logic      label_overflow_o;

    logic [31:0]            rng_state = 32'h3263026b;
    logic [IMG_W*IMG_H-1:0] img;
    bit                     check_objects;  // cleared when only the flag matters
    bit                     timed_out;
    int                     obj_idx;
    int                     done_count;
    int                     value_errors;
    int                     other_errors;

    `include "ccl_model.svh"

    always #5 clk = ~clk;

    ccl_top DUT (
        .clk              (clk),
        .rst_fifo         (rst_fifo),
        .frame_start_i    (frame_start_i),
        .pix_valid_i      (pix_valid_i),
        .pix_i            (pix_i),
        .obj_valid_o      (obj_valid_o),
        .obj_o            (obj_o),
        .frame_done_o     (frame_done_o),
        .label_overflow_o (label_overflow_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_obj(input string name, input obj_info_t got, input obj_info_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t %s got area %0d perimeter %0d expected area %0d perimeter %0d",
                     $time, name, got.area, got.perimeter, exp.area, exp.perimeter);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst_fifo) begin
            if (obj_valid_o && check_objects) begin
                if (obj_idx < exp_count) begin
                    check_obj("obj_o", obj_o, exp_obj[obj_idx]);
                end else begin
                    other_errors++;
                    $display("object %0d at %0t is more than the %0d expected",
                             obj_idx, $time, exp_count);
                end
            end
            if (obj_valid_o)
                obj_idx++;
            if (frame_done_o) begin
                if (check_objects)
                    check_count("object count", obj_idx, exp_count);
                check_flag("label_overflow_o", label_overflow_o, exp_ovf);
                obj_idx = 0;
                done_count++;   // last, so the stimulus moves on after the compare
            end
        end
    end

    task automatic send_frame(input logic [IMG_W*IMG_H-1:0] frame, input bit gaps);
        int n;
        frame_start_i = 1'b1;
        @(negedge clk);
        frame_start_i = 1'b0;
        for (int i = 0; i < IMG_W*IMG_H; i++) begin
            n = gaps ? int'(next_rand() % 3) : 0;
            repeat (n) @(negedge clk);      // idle cycles between strobes
            pix_valid_i = 1'b1;
            pix_i       = frame[i];
            @(negedge clk);
            pix_valid_i = 1'b0;
            pix_i       = 1'b0;
        end
    endtask

    task automatic wait_frame_done();
        int start;
        int cycles;
        start  = done_count;
        cycles = 0;
        while (done_count == start && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count == start) begin
            other_errors++;
            timed_out = 1'b1;
            $display("no frame_done_o within %0d cycles of the last pixel, at %0t",
                     DONE_LIMIT, $time);
        end
    endtask

    task automatic run_frame(input logic [IMG_W*IMG_H-1:0] frame, input bit gaps);
        if (!timed_out) begin   // a hung DUT ends the sequence
            send_frame(frame, gaps);
            wait_frame_done();
        end
    endtask

    initial begin
        rst_fifo      = 1'b1;
        frame_start_i = 1'b0;
        pix_valid_i   = 1'b0;
        pix_i         = 1'b0;
        check_objects = 1'b1;
        timed_out     = 1'b0;
        obj_idx       = 0;
        done_count    = 0;
        value_errors  = 0;
        other_errors  = 0;
        exp_count     = 0;
        exp_ovf       = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_fifo = 1'b0;

        // empty frame
        img = '0;
        run_frame(img, 1'b0);

        // solid 6x4 rectangle
        img = '0;
        for (int y = 2; y < 6; y++)
            for (int x = 3; x < 9; x++)
                img[y*IMG_W+x] = 1'b1;
        exp_count  = 1;
        exp_obj[0] = '{area: 10'd24, perimeter: 12'd20};
        run_frame(img, 1'b0);

        // U shape, arms joined on the bottom row, plus a lone dot
        img = '0;
        for (int y = 1; y < 5; y++) begin
            img[y*IMG_W+2] = 1'b1;
            img[y*IMG_W+6] = 1'b1;
        end
        for (int x = 2; x < 7; x++)
            img[5*IMG_W+x] = 1'b1;
        img[10*IMG_W+20] = 1'b1;
        exp_count  = 2;
        exp_obj[0] = '{area: 10'd13, perimeter: 12'd28};
        exp_obj[1] = '{area: 10'd1, perimeter: 12'd4};
        run_frame(img, 1'b0);

        // random frames near 40% density
        for (int f = 0; f < 20; f++) begin
            for (int i = 0; i < IMG_W*IMG_H; i++)
                img[i] = (next_rand() % 100) < 40;
            ccl_model(img);
            run_frame(img, 1'b1);
        end

        // checkerboard needs 256 labels
        img = '0;
        for (int i = 0; i < IMG_W*IMG_H; i++)
            img[i] = ((i % IMG_W + i / IMG_W) % 2) == 0;
        check_objects = 1'b0;
        exp_ovf       = 1'b1;
        run_frame(img, 1'b0);

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tests
source/ccl_pkg.sv
source/pixel_decode.sv
source/union_fifo.sv
source/union_engine.sv
source/label_stats.sv
source/result_emit.sv
source/ccl_top.sv
tests/ccl_tb.sv
